//--- design/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 4;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [31:0]           ins_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            alu_op_t;

    localparam xlen_t RESET_PC = 32'h3000_0000;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // major opcodes, ins[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef struct packed {
        xlen_t pc;
        ins_t  ins;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     op_a;
        xlen_t     op_b;
        alu_op_t   alu_op;
        reg_addr_t rd;
        logic      wen;
    } issue_pkt_t;

    // also the retire port format
    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     data;
        logic      wen;
    } result_pkt_t;

endpackage

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  logic                    i_ins_valid,
    input  rv_core_pkg::ins_t       i_ins,
    output logic                    o_ins_ready,
    output logic                    o_fetch_valid,
    output rv_core_pkg::fetch_pkt_t o_fetch,
    input  logic                    i_fetch_ready
);

    rv_core_pkg::xlen_t pc;
    logic               take;

    // register free or emptied this cycle
    assign o_ins_ready = !o_fetch_valid || i_fetch_ready;
    assign take        = i_ins_valid && o_ins_ready;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc            <= rv_core_pkg::RESET_PC;
            o_fetch_valid <= 1'b0;
        end else if (take) begin
            pc            <= pc + 32'd4;
            o_fetch_valid <= 1'b1;
        end else if (i_fetch_ready) begin
            o_fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            o_fetch.pc  <= pc;
            o_fetch.ins <= i_ins;
        end
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                   i_clock,
    input  logic                   i_arst_n,
    input  rv_core_pkg::reg_addr_t i_raddr1,
    input  rv_core_pkg::reg_addr_t i_raddr2,
    output rv_core_pkg::xlen_t     o_rdata1,
    output rv_core_pkg::xlen_t     o_rdata2,
    input  rv_core_pkg::reg_addr_t i_check_rd,
    output logic                   o_busy1,
    output logic                   o_busy2,
    output logic                   o_busy_rd,
    input  logic                   i_set_busy,
    input  rv_core_pkg::reg_addr_t i_set_addr,
    input  logic                   i_wen,
    input  rv_core_pkg::reg_addr_t i_waddr,
    input  rv_core_pkg::xlen_t     i_wdata
);

    rv_core_pkg::xlen_t                  regs [2**rv_core_pkg::REG_ADDR_W];
    logic [2**rv_core_pkg::REG_ADDR_W-1:0] busy;

    always_ff @(posedge i_clock) begin
        if (i_wen) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // scoreboard, one pending write per register
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy <= '0;
        end else begin
            if (i_wen) begin
                busy[i_waddr] <= 1'b0;
            end
            if (i_set_busy) begin
                busy[i_set_addr] <= 1'b1;
            end
        end
    end

    // x0 is hardwired to zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

    assign o_busy1   = busy[i_raddr1];
    assign o_busy2   = busy[i_raddr2];
    assign o_busy_rd = busy[i_check_rd];

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  logic                    i_fetch_valid,
    input  rv_core_pkg::fetch_pkt_t i_fetch,
    output logic                    o_fetch_ready,
    output rv_core_pkg::reg_addr_t  o_raddr1,
    output rv_core_pkg::reg_addr_t  o_raddr2,
    input  rv_core_pkg::xlen_t      i_rdata1,
    input  rv_core_pkg::xlen_t      i_rdata2,
    output rv_core_pkg::reg_addr_t  o_check_rd,
    input  logic                    i_busy1,
    input  logic                    i_busy2,
    input  logic                    i_busy_rd,
    output logic                    o_set_busy,
    output rv_core_pkg::reg_addr_t  o_set_addr,
    output logic                    o_issue_valid,
    output rv_core_pkg::issue_pkt_t o_issue,
    input  logic                    i_issue_ready
);

    rv_core_pkg::ins_t       ins;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic                    alt;
    rv_core_pkg::xlen_t      imm_i;
    rv_core_pkg::xlen_t      imm_u;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    hazard;
    logic                    take;
    rv_core_pkg::issue_pkt_t dec;

    assign ins    = i_fetch.ins;
    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    // funct7 bit selecting sub and sra
    assign alt    = ins[30];
    assign imm_i  = {{20{ins[31]}}, ins[31:20]};
    assign imm_u  = {ins[31:12], 12'b0};

    // only the low four bits of each field are kept for RV32E
    assign o_raddr1   = ins[18:15];
    assign o_raddr2   = ins[23:20];
    assign o_check_rd = ins[10:7];

    always_comb begin
        dec.pc     = i_fetch.pc;
        dec.rd     = ins[10:7];
        dec.op_a   = i_rdata1;
        dec.op_b   = imm_i;
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.wen    = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                dec.op_a = '0;
                dec.op_b = imm_u;
                dec.wen  = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                dec.op_a = i_fetch.pc;
                dec.op_b = imm_u;
                dec.wen  = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM, rv_core_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = (opcode == rv_core_pkg::OPC_OP);
                dec.wen = 1'b1;
                if (use_rs2) begin
                    dec.op_b = i_rdata2;
                end
                case (funct3)
                    3'b000:  dec.alu_op = (use_rs2 && alt) ? rv_core_pkg::ALU_SUB
                                                           : rv_core_pkg::ALU_ADD;
                    3'b001:  dec.alu_op = rv_core_pkg::ALU_SLL;
                    3'b010:  dec.alu_op = rv_core_pkg::ALU_SLT;
                    3'b011:  dec.alu_op = rv_core_pkg::ALU_SLTU;
                    3'b100:  dec.alu_op = rv_core_pkg::ALU_XOR;
                    3'b101:  dec.alu_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                    3'b110:  dec.alu_op = rv_core_pkg::ALU_OR;
                    default: dec.alu_op = rv_core_pkg::ALU_AND;
                endcase
            end
            default: begin
                // unknown opcode, retires as a no-op
                dec.wen = 1'b0;
            end
        endcase
        if (dec.rd == '0) begin
            dec.wen = 1'b0;
        end
    end

    // wait for pending writes to sources and to rd
    assign hazard = (use_rs1 && i_busy1) || (use_rs2 && i_busy2) || (dec.wen && i_busy_rd);

    assign o_fetch_ready = !hazard && (!o_issue_valid || i_issue_ready);
    assign take          = i_fetch_valid && o_fetch_ready;

    assign o_set_busy = take && dec.wen;
    assign o_set_addr = dec.rd;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_issue_valid <= 1'b0;
        end else if (take) begin
            o_issue_valid <= 1'b1;
        end else if (i_issue_ready) begin
            o_issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            o_issue <= dec;
        end
    end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                     i_clock,
    input  logic                     i_arst_n,
    input  logic                     i_issue_valid,
    input  rv_core_pkg::issue_pkt_t  i_issue,
    output logic                     o_issue_ready,
    output logic                     o_result_valid,
    output rv_core_pkg::result_pkt_t o_result,
    input  logic                     i_result_ready
);

    rv_core_pkg::xlen_t alu_res;
    logic [4:0]         shamt;
    logic               take;

    assign shamt = i_issue.op_b[4:0];

    always_comb begin
        case (i_issue.alu_op)
            rv_core_pkg::ALU_ADD:  alu_res = i_issue.op_a + i_issue.op_b;
            rv_core_pkg::ALU_SUB:  alu_res = i_issue.op_a - i_issue.op_b;
            rv_core_pkg::ALU_SLL:  alu_res = i_issue.op_a << shamt;
            rv_core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(i_issue.op_a) < $signed(i_issue.op_b)};
            rv_core_pkg::ALU_SLTU: alu_res = {31'b0, i_issue.op_a < i_issue.op_b};
            rv_core_pkg::ALU_XOR:  alu_res = i_issue.op_a ^ i_issue.op_b;
            rv_core_pkg::ALU_SRL:  alu_res = i_issue.op_a >> shamt;
            rv_core_pkg::ALU_SRA:  alu_res = $unsigned($signed(i_issue.op_a) >>> shamt);
            rv_core_pkg::ALU_OR:   alu_res = i_issue.op_a | i_issue.op_b;
            rv_core_pkg::ALU_AND:  alu_res = i_issue.op_a & i_issue.op_b;
            default:               alu_res = '0;
        endcase
    end

    assign o_issue_ready = !o_result_valid || i_result_ready;
    assign take          = i_issue_valid && o_issue_ready;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_result_valid <= 1'b0;
        end else if (take) begin
            o_result_valid <= 1'b1;
        end else if (i_result_ready) begin
            o_result_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            o_result.pc   <= i_issue.pc;
            o_result.rd   <= i_issue.rd;
            o_result.data <= alu_res;
            o_result.wen  <= i_issue.wen;
        end
    end

endmodule

//--- design/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                     i_clock,
    input  logic                     i_arst_n,
    input  logic                     i_result_valid,
    input  rv_core_pkg::result_pkt_t i_result,
    output logic                     o_result_ready,
    output logic                     o_rf_wen,
    output rv_core_pkg::reg_addr_t   o_rf_waddr,
    output rv_core_pkg::xlen_t       o_rf_wdata,
    output logic                     o_retire_valid,
    output rv_core_pkg::result_pkt_t o_retire,
    input  logic                     i_retire_ready
);

    logic take;

    assign o_result_ready = !o_retire_valid || i_retire_ready;
    assign take           = i_result_valid && o_result_ready;

    // register write lands on the same edge as the retire load
    assign o_rf_wen   = take && i_result.wen;
    assign o_rf_waddr = i_result.rd;
    assign o_rf_wdata = i_result.data;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_retire_valid <= 1'b0;
        end else if (take) begin
            o_retire_valid <= 1'b1;
        end else if (i_retire_ready) begin
            o_retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            o_retire <= i_result;
        end
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                     i_clock,
    input  logic                     i_arst_n,
    input  logic                     i_ins_valid,
    input  rv_core_pkg::ins_t        i_ins,
    output logic                     o_ins_ready,
    output logic                     o_retire_valid,
    output rv_core_pkg::result_pkt_t o_retire,
    input  logic                     i_retire_ready
);

    logic                     fetch_valid, fetch_ready;
    rv_core_pkg::fetch_pkt_t  fetch_pkt;
    logic                     issue_valid, issue_ready;
    rv_core_pkg::issue_pkt_t  issue_pkt;
    logic                     result_valid, result_ready;
    rv_core_pkg::result_pkt_t result_pkt;

    rv_core_pkg::reg_addr_t   raddr1, raddr2, check_rd, set_addr, waddr;
    rv_core_pkg::xlen_t       rdata1, rdata2, wdata;
    logic                     busy1, busy2, busy_rd, set_busy, wen;

    fetch_stage u_fetch (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_ins_valid   (i_ins_valid),
        .i_ins         (i_ins),
        .o_ins_ready   (o_ins_ready),
        .o_fetch_valid (fetch_valid),
        .o_fetch       (fetch_pkt),
        .i_fetch_ready (fetch_ready)
    );

    decode_stage u_decode (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_fetch_valid (fetch_valid),
        .i_fetch       (fetch_pkt),
        .o_fetch_ready (fetch_ready),
        .o_raddr1      (raddr1),
        .o_raddr2      (raddr2),
        .i_rdata1      (rdata1),
        .i_rdata2      (rdata2),
        .o_check_rd    (check_rd),
        .i_busy1       (busy1),
        .i_busy2       (busy2),
        .i_busy_rd     (busy_rd),
        .o_set_busy    (set_busy),
        .o_set_addr    (set_addr),
        .o_issue_valid (issue_valid),
        .o_issue       (issue_pkt),
        .i_issue_ready (issue_ready)
    );

    execute_stage u_execute (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_issue_valid  (issue_valid),
        .i_issue        (issue_pkt),
        .o_issue_ready  (issue_ready),
        .o_result_valid (result_valid),
        .o_result       (result_pkt),
        .i_result_ready (result_ready)
    );

    writeback_stage u_writeback (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_result_valid (result_valid),
        .i_result       (result_pkt),
        .o_result_ready (result_ready),
        .o_rf_wen       (wen),
        .o_rf_waddr     (waddr),
        .o_rf_wdata     (wdata),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire),
        .i_retire_ready (i_retire_ready)
    );

    // register file with scoreboard
    register_file u_regfile (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_raddr1   (raddr1),
        .i_raddr2   (raddr2),
        .o_rdata1   (rdata1),
        .o_rdata2   (rdata2),
        .i_check_rd (check_rd),
        .o_busy1    (busy1),
        .o_busy2    (busy2),
        .o_busy_rd  (busy_rd),
        .i_set_busy (set_busy),
        .i_set_addr (set_addr),
        .i_wen      (wen),
        .i_waddr    (waddr),
        .i_wdata    (wdata)
    );

endmodule

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int          MAX_TESTS = 63;
    localparam logic [31:0] SEED      = 32'ha5f7;

    logic                     clock;
    logic                     i_arst_n;
    logic                     i_ins_valid;
    rv_core_pkg::ins_t        i_ins;
    logic                     o_ins_ready;
    logic                     o_retire_valid;
    rv_core_pkg::result_pkt_t o_retire;
    logic                     i_retire_ready;

    // word 0 is the test count, then four words per test
    logic [31:0] test_mem [256];
    int          num_tests;
    int          cycle_limit;
    int          cycle_count = 0;
    logic        running;
    logic [31:0] stim_seed;
    logic [31:0] ready_seed;

    rv_core dut (
        .i_clock        (clock),
        .i_arst_n       (i_arst_n),
        .i_ins_valid    (i_ins_valid),
        .i_ins          (i_ins),
        .o_ins_ready    (o_ins_ready),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire),
        .i_retire_ready (i_retire_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_xlen(input string name, input rv_core_pkg::xlen_t got,
                              input rv_core_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input string name, input rv_core_pkg::reg_addr_t got,
                                  input rv_core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_stimulus();
        logic [7:0] base;
        logic [1:0] idle;
        logic       taken;
        for (int idx = 0; idx < num_tests; idx++) begin
            stim_seed = lcg_next(stim_seed);
            // gap of 0 to 3 cycles, about half the time none
            idle = stim_seed[18] ? stim_seed[17:16] : 2'd0;
            repeat (idle) begin
                @(posedge clock);
                #1;
            end
            base        = 8'(4 * idx + 1);
            i_ins_valid = 1'b1;
            i_ins       = test_mem[base];
            do begin
                @(negedge clock);
                taken = o_ins_ready;
                @(posedge clock);
                #1;
            end while (!taken);
            i_ins_valid = 1'b0;
            i_ins       = '0;
        end
    endtask

    // retire back-pressure
    initial begin
        i_retire_ready = 1'b0;
        ready_seed     = lcg_next(SEED);
        forever begin
            @(posedge clock);
            #1;
            if (running) begin
                ready_seed     = lcg_next(ready_seed);
                i_retire_ready = (ready_seed[21:20] != 2'b00);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout reached after %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial begin : main
        rv_core_pkg::result_pkt_t got;
        logic [7:0]               base;
        logic                     seen;

        i_arst_n    = 1'b0;
        i_ins_valid = 1'b0;
        i_ins       = '0;
        running     = 1'b0;
        stim_seed   = SEED;
        cycle_limit = 200;
        $readmemh("verification/rv_core_tests.txt", test_mem);
        num_tests = int'(test_mem[8'd0]);
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            $display("test file holds a bad test count of %0d", num_tests);
            abort_run();
        end
        cycle_limit = 40 * num_tests + 200;

        repeat (5) @(posedge clock);
        running = 1'b1;
        #1;
        i_arst_n = 1'b1;
        // pipeline comes out of reset empty
        check_bit("o_retire_valid", o_retire_valid, 1'b0);
        check_bit("o_ins_ready", o_ins_ready, 1'b1);

        fork
            drive_stimulus();
        join_none

        for (int idx = 0; idx < num_tests; idx++) begin
            do begin
                @(negedge clock);
                seen = o_retire_valid && i_retire_ready;
                got  = o_retire;
                @(posedge clock);
            end while (!seen);
            base = 8'(4 * idx + 1);
            check_xlen("o_retire.pc", got.pc,
                       rv_core_pkg::RESET_PC + rv_core_pkg::xlen_t'(4 * idx));
            check_reg_addr("o_retire.rd", got.rd, test_mem[base + 8'd1][3:0]);
            check_bit("o_retire.wen", got.wen, test_mem[base + 8'd2][0]);
            // data only matters when a register is written
            if (test_mem[base + 8'd2][0]) begin
                check_xlen("o_retire.data", got.data, test_mem[base + 8'd3]);
            end
        end

        // nothing may retire past the last test
        repeat (10) begin
            @(negedge clock);
            if (o_retire_valid) begin
                $display("an extra instruction retired after the last test");
                abort_run();
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- verification/rv_core_tests.txt
// columns: instruction word, expected rd, expected wen, expected result (checked when wen is 1)
// the first word is the number of tests
24
00500093 1 1 00000005
ffd00113 2 1 fffffffd
fff08193 3 1 00000004
ffe12213 4 1 00000001
ffe13293 5 1 00000001
0050b313 6 1 00000000
0f014393 7 1 ffffff0d
7f00e413 8 1 000007f5
0ff3f493 9 1 0000000d
00409513 a 1 00000050
01c15593 b 1 0000000f
40115613 c 1 fffffffe
4043d693 d 1 fffffff0
// register ops
00208733 e 1 00000002
402087b3 f 1 00000008
003091b3 3 1 00000050
00112233 4 1 00000001
001132b3 5 1 00000000
0083c333 6 1 fffff8f8
001154b3 9 1 07ffffff
40115533 a 1 ffffffff
0080e5b3 b 1 000007f5
0083f633 c 1 00000705
// lui and auipc
123456b7 d 1 12345000
00001717 e 1 30001060
fffff797 f 1 2ffff064
// x0 writes and an unsupported load opcode
00108013 0 0 00000000
00208033 0 0 00000000
0000a083 1 0 00000000
00100133 2 1 00000005
7ff00193 3 1 000007ff
// dependent chains
00120213 4 1 00000002
00120213 4 1 00000003
402202b3 5 1 fffffffe
00503333 6 1 00000001
0002a3b3 7 1 00000001

//--- verilog.f
design/rv_core_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/rv_core.sv
verification/rv_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/1ps
TOP       = rv_core_tb
RTL_TOP   = rv_core
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
